// File: common/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// Address and word widths, the bus word equals the cache word
`define DC_ADDR_W     16
`define DC_DATA_W     32

// Cache geometry
`define DC_LINE_LOG2  4
`define DC_SETS_LOG2  4
`define DC_WAYS       2

// Derived widths
`define DC_WORD_LOG2  ($clog2(`DC_DATA_W / 8))
`define DC_BEAT_W     (`DC_LINE_LOG2 - `DC_WORD_LOG2)
`define DC_TAG_W      (`DC_ADDR_W - `DC_SETS_LOG2 - `DC_LINE_LOG2)
`define DC_WAY_W      ($clog2(`DC_WAYS))

`endif

// File: common/dcache_pkg.sv
`include "dcache_settings.svh"

package dcache_pkg;

   typedef logic [`DC_ADDR_W-1:0]                 paddr_t;
   typedef logic [`DC_DATA_W-1:0]                 word_t;
   typedef logic [`DC_DATA_W/8-1:0]               wmask_t;
   typedef logic [`DC_SETS_LOG2-1:0]              set_idx_t;
   typedef logic [`DC_TAG_W-1:0]                  tag_t;
   typedef logic [`DC_BEAT_W-1:0]                 beat_t;
   typedef logic [`DC_WAY_W-1:0]                  way_t;
   // Rank 0 is the victim, all ones the most recent way
   typedef logic [`DC_WAY_W-1:0]                  lru_t;
   typedef logic [`DC_SETS_LOG2+`DC_BEAT_W-1:0]   blk_addr_t;

   typedef enum logic [2:0] {
      ST_BOOT,
      ST_IDLE,
      ST_WRITE_BACK,
      ST_WAIT_RESP,
      ST_REFILL,
      ST_READOUT
   } cache_state_e;

   // Zero mask means a read
   typedef struct packed {
      logic   valid;
      paddr_t addr;
      wmask_t wmsk;
      word_t  wdat;
   } cpu_req_t;

   typedef struct packed {
      logic hit;
      way_t hit_way;
      way_t victim_way;
      logic victim_dirty;
      tag_t victim_tag;
   } lookup_t;

   typedef struct packed {
      logic   arw_valid;
      paddr_t arw_addr;
      logic   awe;
      logic   w_valid;
      word_t  w_data;
      logic   b_ready;
      logic   r_ready;
   } bus_req_t;

   typedef struct packed {
      logic  arw_ready;
      logic  w_ready;
      logic  b_valid;
      logic  r_valid;
      word_t r_data;
   } bus_rsp_t;

endpackage

// File: source/dcache_beat_counter.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_beat_counter
   import dcache_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  cache_state_e state,
   input  logic         beat_step,
   output beat_t        beat,
   output set_idx_t     boot_set
);

   // Shared by write-back and refill, wraps after the last beat
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         beat <= '0;
      else if (beat_step)
         beat <= beat + 1'b1;
   end

   // Boot sweep walks the sets from the top down
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         boot_set <= '1;
      else if (state == ST_BOOT)
         boot_set <= boot_set - 1'b1;
   end

endmodule

// File: source/dcache_fsm.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_fsm
   import dcache_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  cpu_req_t     s1_req,
   input  lookup_t      lookup,
   input  beat_t        beat,
   input  set_idx_t     boot_set,
   input  bus_rsp_t     bus_rsp,
   output cache_state_e state,
   output logic         beat_step,
   output bus_req_t     bus_req
);

   cache_state_e state_nxt;
   set_idx_t     s1_set;
   paddr_t       req_line;
   paddr_t       victim_line;
   paddr_t       arw_addr;
   logic         miss;
   logic         last_beat;
   logic         w_hs;
   logic         r_hs;
   logic         b_hs;
   logic         a_set;
   logic         arw_valid;
   logic         awe;
   logic         w_valid;

   assign s1_set      = s1_req.addr[`DC_LINE_LOG2 +: `DC_SETS_LOG2];
   assign req_line    = {s1_req.addr[`DC_ADDR_W-1:`DC_LINE_LOG2], {`DC_LINE_LOG2{1'b0}}};
   assign victim_line = {lookup.victim_tag, s1_set, {`DC_LINE_LOG2{1'b0}}};

   assign miss      = (state == ST_IDLE) && s1_req.valid && !lookup.hit;
   assign last_beat = &beat;
   assign w_hs      = w_valid && bus_rsp.w_ready;
   assign r_hs      = (state == ST_REFILL) && bus_rsp.r_valid;
   assign b_hs      = (state == ST_WAIT_RESP) && bus_rsp.b_valid;
   assign beat_step = w_hs || r_hs;

   always_comb
   begin
      state_nxt = state;
      case (state)
         ST_BOOT:       if (boot_set == '0) state_nxt = ST_READOUT;
         ST_IDLE:
            if (miss)
               state_nxt = lookup.victim_dirty ? ST_WRITE_BACK : ST_REFILL;
         ST_WRITE_BACK: if (w_hs && last_beat) state_nxt = ST_WAIT_RESP;
         ST_WAIT_RESP:  if (b_hs) state_nxt = ST_REFILL;
         ST_REFILL:     if (r_hs && last_beat) state_nxt = ST_READOUT;
         ST_READOUT:    state_nxt = ST_IDLE;
         default:       state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         state <= ST_BOOT;
      else
         state <= state_nxt;
   end

   // New address phase on a miss and again after the write response
   assign a_set = miss || b_hs;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         arw_valid <= 1'b0;
         awe       <= 1'b0;
      end
      else if (a_set)
      begin
         arw_valid <= 1'b1;
         awe       <= miss && lookup.victim_dirty;
      end
      else if (arw_valid && bus_rsp.arw_ready)
         arw_valid <= 1'b0;
   end

   // Address only moves while no address phase is pending
   always_ff @(posedge clk)
   begin
      if (a_set)
         arw_addr <= (miss && lookup.victim_dirty) ? victim_line : req_line;
   end

   // Data store fetches a beat while w_valid is low, so each beat takes two cycles
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         w_valid <= 1'b0;
      else if (state == ST_WRITE_BACK && bus_rsp.w_ready && !w_valid)
         w_valid <= 1'b1;
      else if (w_hs)
         w_valid <= 1'b0;
   end

   always_comb
   begin
      bus_req           = '0;
      bus_req.arw_valid = arw_valid;
      bus_req.arw_addr  = arw_addr;
      bus_req.awe       = awe;
      bus_req.w_valid   = w_valid;
      bus_req.b_ready   = (state == ST_WAIT_RESP);
      bus_req.r_ready   = 1'b1;
      // w_data comes from the data store
   end

endmodule

// File: source/dcache_tag_store.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_tag_store
   import dcache_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  cache_state_e state,
   input  set_idx_t     rd_set,
   input  set_idx_t     boot_set,
   input  cpu_req_t     s1_req,
   output lookup_t      lookup
);

   logic                valid_mem [`DC_WAYS][(1 << `DC_SETS_LOG2)];
   logic                dirty_mem [`DC_WAYS][(1 << `DC_SETS_LOG2)];
   tag_t                tag_mem   [`DC_WAYS][(1 << `DC_SETS_LOG2)];
   lru_t                lru_mem   [`DC_WAYS][(1 << `DC_SETS_LOG2)];

   logic [`DC_WAYS-1:0] rd_valid;
   logic [`DC_WAYS-1:0] rd_dirty;
   tag_t [`DC_WAYS-1:0] rd_tag;
   lru_t [`DC_WAYS-1:0] rd_lru;
   logic [`DC_WAYS-1:0] wr_valid;
   logic [`DC_WAYS-1:0] wr_dirty;
   tag_t [`DC_WAYS-1:0] wr_tag;
   lru_t [`DC_WAYS-1:0] wr_lru;
   logic [`DC_WAYS-1:0] match;
   lru_t                thresh;
   way_t                hit_way;
   way_t                victim;
   set_idx_t            wr_set;
   tag_t                req_tag;
   logic                req_write;
   logic                tag_we;
   logic                lru_we;
   logic                rd_en;

   assign req_tag   = s1_req.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
   assign req_write = |s1_req.wmsk;

   always_comb
   begin
      match   = '0;
      thresh  = '0;
      hit_way = '0;
      victim  = '0;
      for (int w = 0; w < `DC_WAYS; w++)
      begin
         match[w] = rd_valid[w] && (rd_tag[w] == req_tag);
         if (match[w])
         begin
            thresh  = rd_lru[w];
            hit_way = way_t'(w);
         end
         if (rd_lru[w] == '0)
            victim = way_t'(w);
      end
      lookup.hit          = |match;
      lookup.hit_way      = hit_way;
      lookup.victim_way   = victim;
      lookup.victim_dirty = rd_dirty[victim];
      lookup.victim_tag   = rd_tag[victim];
   end

   always_comb
   begin
      wr_set   = s1_req.addr[`DC_LINE_LOG2 +: `DC_SETS_LOG2];
      wr_valid = rd_valid;
      wr_dirty = rd_dirty;
      wr_tag   = rd_tag;
      wr_lru   = rd_lru;
      tag_we   = 1'b0;
      lru_we   = 1'b0;
      if (state == ST_BOOT)
      begin
         wr_set   = boot_set;
         wr_valid = '0;
         wr_dirty = '0;
         wr_tag   = '0;
         tag_we   = 1'b1;
         lru_we   = 1'b1;
         for (int w = 0; w < `DC_WAYS; w++)
            wr_lru[w] = lru_t'(w);
      end
      else if (state == ST_IDLE && s1_req.valid && lookup.hit)
      begin
         // Promote the hit way, ranks above it step down
         tag_we = req_write;
         lru_we = 1'b1;
         for (int w = 0; w < `DC_WAYS; w++)
         begin
            if (match[w])
            begin
               wr_lru[w]   = '1;
               wr_dirty[w] = rd_dirty[w] || req_write;
            end
            else
               wr_lru[w] = lru_t'(rd_lru[w] - lru_t'(rd_lru[w] > thresh));
         end
      end
      else if (state == ST_IDLE && s1_req.valid)
      begin
         // Victim takes the new line, refill follows
         tag_we           = 1'b1;
         wr_valid[victim] = 1'b1;
         wr_dirty[victim] = 1'b0;
         wr_tag[victim]   = req_tag;
      end
   end

   always_ff @(posedge clk)
   begin
      for (int w = 0; w < `DC_WAYS; w++)
      begin
         if (tag_we)
         begin
            valid_mem[w][wr_set] <= wr_valid[w];
            dirty_mem[w][wr_set] <= wr_dirty[w];
            tag_mem[w][wr_set]   <= wr_tag[w];
         end
         if (lru_we)
            lru_mem[w][wr_set] <= wr_lru[w];
      end
   end

   // Readout refreshes the held set after a refill
   assign rd_en = (state == ST_IDLE && !(s1_req.valid && !lookup.hit))
                  || (state == ST_READOUT);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rd_valid <= '0;
         rd_dirty <= '0;
         rd_tag   <= '0;
         rd_lru   <= '0;
      end
      else if (rd_en)
      begin
         for (int w = 0; w < `DC_WAYS; w++)
         begin
            // Same-set write in this cycle wins over the array
            if (tag_we && wr_set == rd_set)
            begin
               rd_valid[w] <= wr_valid[w];
               rd_dirty[w] <= wr_dirty[w];
               rd_tag[w]   <= wr_tag[w];
            end
            else
            begin
               rd_valid[w] <= valid_mem[w][rd_set];
               rd_dirty[w] <= dirty_mem[w][rd_set];
               rd_tag[w]   <= tag_mem[w][rd_set];
            end
            if (lru_we && wr_set == rd_set)
               rd_lru[w] <= wr_lru[w];
            else
               rd_lru[w] <= lru_mem[w][rd_set];
         end
      end
   end

endmodule

// File: source/dcache_data_store.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_data_store
   import dcache_pkg::*;
(
   input  logic         clk,
   input  cache_state_e state,
   input  blk_addr_t    rd_addr,
   input  logic         rd_en,
   input  cpu_req_t     s1_req,
   input  lookup_t      lookup,
   input  beat_t        beat,
   input  bus_rsp_t     bus_rsp,
   output word_t        rdat,
   output word_t        w_data
);

   word_t     ram [`DC_WAYS][(1 << (`DC_SETS_LOG2 + `DC_BEAT_W))];
   word_t     dout_a [`DC_WAYS];
   word_t     dout_b [`DC_WAYS];
   blk_addr_t addr_a;
   word_t     din_a;
   wmask_t    we_a;
   way_t      way_a;
   logic      en_a;
   logic      burst;
   logic      conflict;
   wmask_t    byp_mask;
   word_t     byp_data;
   way_t      byp_way;

   // Port A follows the burst beat during write-back and refill
   always_comb
   begin
      burst  = (state == ST_WRITE_BACK) || (state == ST_REFILL);
      addr_a = {s1_req.addr[`DC_LINE_LOG2 +: `DC_SETS_LOG2],
                burst ? beat : s1_req.addr[`DC_WORD_LOG2 +: `DC_BEAT_W]};
      way_a  = burst ? lookup.victim_way : lookup.hit_way;
      din_a  = burst ? bus_rsp.r_data : s1_req.wdat;
      case (state)
         ST_IDLE:       en_a = s1_req.valid && lookup.hit;
         ST_WRITE_BACK: en_a = bus_rsp.w_ready;
         ST_REFILL:     en_a = bus_rsp.r_valid;
         default:       en_a = 1'b0;
      endcase
      if (state == ST_IDLE && en_a)
         we_a = s1_req.wmsk;
      else if (state == ST_REFILL && en_a)
         we_a = '1;
      else
         we_a = '0;
   end

   always_ff @(posedge clk)
   begin
      for (int w = 0; w < `DC_WAYS; w++)
      begin
         if (en_a && way_a == way_t'(w))
         begin
            for (int b = 0; b < `DC_DATA_W / 8; b++)
               if (we_a[b])
                  ram[w][addr_a][b*8 +: 8] <= din_a[b*8 +: 8];
            dout_a[w] <= ram[w][addr_a];
         end
         if (rd_en)
            dout_b[w] <= ram[w][rd_addr];
      end
   end

   // Port B sees old data when port A writes the same word
   assign conflict = rd_en && en_a && (|we_a) && (addr_a == rd_addr);

   always_ff @(posedge clk)
   begin
      if (rd_en)
      begin
         byp_mask <= conflict ? we_a : '0;
         byp_data <= din_a;
         byp_way  <= way_a;
      end
   end

   always_comb
   begin
      rdat = dout_b[lookup.hit_way];
      for (int b = 0; b < `DC_DATA_W / 8; b++)
         if (byp_mask[b] && byp_way == lookup.hit_way)
            rdat[b*8 +: 8] = byp_data[b*8 +: 8];
   end

   assign w_data = dout_a[lookup.victim_way];

endmodule

// File: source/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_top
   import dcache_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  cpu_req_t cpu_req,
   output logic     stall,
   output word_t    rdat,
   output bus_req_t bus_req,
   input  bus_rsp_t bus_rsp
);

   cpu_req_t     s1_req;
   cache_state_e state;
   lookup_t      lookup;
   beat_t        beat;
   set_idx_t     boot_set;
   logic         beat_step;
   bus_req_t     fsm_bus_req;
   word_t        w_data;
   paddr_t       rd_paddr;
   blk_addr_t    rd_addr;
   logic         rd_en;

   assign stall = (state != ST_IDLE) || (s1_req.valid && !lookup.hit);

   // Stage 1 holds the request until it is answered
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         s1_req <= '0;
      else if (!stall)
         s1_req <= cpu_req;
   end

   // Read the incoming request, or re-read the held one while stalled
   assign rd_paddr = stall ? s1_req.addr : cpu_req.addr;
   assign rd_addr  = {rd_paddr[`DC_LINE_LOG2 +: `DC_SETS_LOG2],
                      rd_paddr[`DC_WORD_LOG2 +: `DC_BEAT_W]};
   assign rd_en    = (!stall && cpu_req.valid) || (state == ST_READOUT);

   dcache_fsm u_fsm (
      .clk       (clk),
      .rst_n     (rst_n),
      .s1_req    (s1_req),
      .lookup    (lookup),
      .beat      (beat),
      .boot_set  (boot_set),
      .bus_rsp   (bus_rsp),
      .state     (state),
      .beat_step (beat_step),
      .bus_req   (fsm_bus_req)
   );

   dcache_beat_counter u_beat_counter (
      .clk       (clk),
      .rst_n     (rst_n),
      .state     (state),
      .beat_step (beat_step),
      .beat      (beat),
      .boot_set  (boot_set)
   );

   dcache_tag_store u_tag_store (
      .clk      (clk),
      .rst_n    (rst_n),
      .state    (state),
      .rd_set   (rd_paddr[`DC_LINE_LOG2 +: `DC_SETS_LOG2]),
      .boot_set (boot_set),
      .s1_req   (s1_req),
      .lookup   (lookup)
   );

   dcache_data_store u_data_store (
      .clk     (clk),
      .state   (state),
      .rd_addr (rd_addr),
      .rd_en   (rd_en),
      .s1_req  (s1_req),
      .lookup  (lookup),
      .beat    (beat),
      .bus_rsp (bus_rsp),
      .rdat    (rdat),
      .w_data  (w_data)
   );

   always_comb
   begin
      bus_req        = fsm_bus_req;
      bus_req.w_data = w_data;
   end

endmodule

// File: dv/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb
   import dcache_pkg::*;
();

   logic      clk = 1'b0;
   logic      rst_n;
   cpu_req_t  cpu_req;
   logic      stall;
   word_t     rdat;
   bus_req_t  bus_req;
   bus_rsp_t  bus_rsp = '0;

   // Six columns per operation as laid out in the data file
   word_t       td [0:255];
   int          n_ops = 0;
   int          value_errs = 0;
   int          other_errs = 0;

   // Bus memory model
   word_t       mem [0:16383];
   logic [13:0] wr_ptr;
   logic [13:0] rd_ptr;
   logic [2:0]  wr_left;
   logic [2:0]  rd_left;
   logic        b_pend;
   int          arw_total = 0;
   int          w_total = 0;
   paddr_t      arw_addr_q [$];
   logic        arw_awe_q [$];
   logic [31:0] lfsr = 32'hc24e1cff;

   dcache_top u_dut (
      .clk     (clk),
      .rst_n   (rst_n),
      .cpu_req (cpu_req),
      .stall   (stall),
      .rdat    (rdat),
      .bus_req (bus_req),
      .bus_rsp (bus_rsp)
   );

   always #20 clk = ~clk;

   function automatic logic take_bit();
      logic fb;
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic word_t field(input int j, input int k);
      return td[8'(j * 6 + k)];
   endfunction

   function automatic cpu_req_t make_req(input int j);
      cpu_req_t r;
      word_t    a;
      word_t    m;
      a = field(j, 1);
      m = field(j, 2);
      r.valid = 1'b1;
      r.addr  = a[15:0];
      r.wmsk  = m[3:0];
      r.wdat  = field(j, 3);
      return r;
   endfunction

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp)
      begin
         value_errs++;
         $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_addr(input string name, input paddr_t got, input paddr_t exp);
      if (got !== exp)
      begin
         value_errs++;
         $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic note_error(input string msg);
      other_errs++;
      $display("ERROR t=%0t %s", $time, msg);
   endtask

   // Upper op nibble counts the expected address handshakes and bit 0 marks a write
   task automatic check_response(input int j, input int cycles, input int arw_base,
                                 input int w_base);
      word_t op;
      word_t baddr;
      int    exp_hs;
      op     = field(j, 0);
      baddr  = field(j, 5);
      exp_hs = int'(op >> 4);
      check_word("arw handshakes", word_t'(arw_total - arw_base), word_t'(exp_hs));
      if (exp_hs == 0 && cycles != 1)
         note_error($sformatf("op %0d answered after %0d cycles instead of 1", j, cycles));
      if (exp_hs > 0 && arw_addr_q.size() > 0)
      begin
         check_addr("arw_addr", arw_addr_q[0], baddr[15:0]);
         check_word("awe", word_t'(arw_awe_q[0]), word_t'(exp_hs == 2));
      end
      if (exp_hs == 2)
      begin
         check_word("w beats", word_t'(w_total - w_base), word_t'(4));
         if (b_pend)
            note_error($sformatf("op %0d write response was never accepted", j));
      end
      if (op[0] == 1'b0)
         check_word("rdat", rdat, field(j, 4));
   endtask

   // Memory answers with random ready and valid
   always @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < 16384; i++)
            mem[i[13:0]] = {~i[15:0], i[15:0]};
         wr_left = '0;
         rd_left = '0;
         b_pend  = 1'b0;
      end
      else
      begin
         if (bus_req.arw_valid && bus_rsp.arw_ready)
         begin
            arw_total++;
            arw_addr_q.push_back(bus_req.arw_addr);
            arw_awe_q.push_back(bus_req.awe);
            if (bus_req.awe)
            begin
               wr_ptr  = bus_req.arw_addr[15:2];
               wr_left = 3'd4;
            end
            else
            begin
               rd_ptr  = bus_req.arw_addr[15:2];
               rd_left = 3'd4;
            end
         end
         if (bus_req.w_valid && bus_rsp.w_ready)
         begin
            mem[wr_ptr] = bus_req.w_data;
            wr_ptr  = wr_ptr + 1'b1;
            wr_left = wr_left - 1'b1;
            w_total++;
            if (wr_left == 0)
               b_pend = 1'b1;
         end
         if (bus_rsp.b_valid && bus_req.b_ready)
            b_pend = 1'b0;
         if (bus_rsp.r_valid && bus_req.r_ready)
         begin
            rd_ptr  = rd_ptr + 1'b1;
            rd_left = rd_left - 1'b1;
         end
      end
      bus_rsp.arw_ready <= rst_n && take_bit();
      bus_rsp.w_ready   <= (wr_left > 0) && take_bit();
      bus_rsp.r_valid   <= (rd_left > 0) && take_bit();
      bus_rsp.r_data    <= mem[rd_ptr];
      bus_rsp.b_valid   <= b_pend;
   end

   initial
   begin
      int cycles;
      int arw_base;
      int w_base;
      cycles   = 0;
      arw_base = 0;
      w_base   = 0;
      rst_n    = 1'b0;
      cpu_req  = '0;
      $readmemh("dv/dcache_testdata.txt", td);
      while (n_ops < 40 && field(n_ops, 0) != 32'hff)
         n_ops++;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      if (!stall)
         note_error("stall is low right after reset, boot sweep missing");
      @(posedge clk);
      cpu_req <= make_req(0);
      for (int i = 0; i <= n_ops; i++)
      begin
         do
         begin
            @(negedge clk);
            cycles++;
         end
         while (stall);
         if (i == 0)
         begin
            if (arw_total != 0)
               note_error("address handshake seen during the boot sweep");
            // Sixteen boot cycles and one readout cycle
            if (cycles != 17)
               note_error($sformatf("boot sweep took %0d cycles instead of 17", cycles));
         end
         else
            check_response(i - 1, cycles, arw_base, w_base);
         if (i < n_ops)
         begin
            arw_base = arw_total;
            w_base   = w_total;
            arw_addr_q.delete();
            arw_awe_q.delete();
            // Next request goes out on the acceptance edge
            @(posedge clk);
            cycles = 0;
            if (i + 1 < n_ops)
               cpu_req <= make_req(i + 1);
            else
               cpu_req <= '0;
         end
      end
      $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
      if (value_errs + other_errs == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

   initial
   begin
      #1;
      repeat (n_ops * 200 + 20) @(posedge clk);
      $display("watchdog expired, the cache stopped answering");
      $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs + 1);
      $display("TEST FAIL");
      $finish;
   end

endmodule

// File: dv/dcache_testdata.txt
// op addr mask wdata expected_rdat first_bus_addr (hex)
// op: upper nibble = address handshakes, bit 0 = write; ff ends the list
10 0004 0 00000000 fffe0001 0000
00 0008 0 00000000 fffd0002 0000
01 0008 3 aabbccdd 00000000 0000
00 0008 0 00000000 fffdccdd 0000
10 0104 0 00000000 ffbe0041 0100
20 0200 0 00000000 ff7f0080 0000
00 0204 0 00000000 ff7e0081 0000
10 0008 0 00000000 fffdccdd 0000
10 0010 0 00000000 fffb0004 0010
10 0110 0 00000000 ffbb0044 0110
00 0010 0 00000000 fffb0004 0000
10 0210 0 00000000 ff7b0084 0210
00 0014 0 00000000 fffa0005 0000
ff

// File: dcache.f
+incdir+common
common/dcache_pkg.sv
source/dcache_beat_counter.sv
source/dcache_fsm.sv
source/dcache_tag_store.sv
source/dcache_data_store.sv
source/dcache_top.sv
dv/dcache_tb.sv

// File: Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --top-module dcache_tb -f dcache.f -o sim_dcache
	@out=$$(./obj_dir/sim_dcache); echo "$$out"; echo "$$out" | grep -qx 'TEST PASS'

lint:
	verilator --lint-only --timing -Wall --top-module dcache_tb -f dcache.f

clean:
	rm -rf obj_dir
